// File: flist.f
source/core_pkg.sv
source/isa_pkg.sv
source/serial_ctrl_if.sv
source/op_if.sv
source/serial_state.sv
source/instr_decode.sv
source/serial_regfile.sv
source/serial_alu.sv
source/serial_pc.sv
source/bit_core_top.sv
bench/tb_bit_core.sv

// File: run.sh
#!/bin/bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ps -Wno-fatal \
   -f flist.f --top-module tb_bit_core -o sim_bit_core

./obj_dir/sim_bit_core | tee sim.log

if grep -q "Test failed" sim.log; then
   echo "simulation reported a failure"
   exit 1
fi
echo "simulation finished without a failure"

// File: bench/tb_bit_core.sv
module tb_bit_core;
   timeunit 1ns;
   timeprecision 1ps;
   import core_pkg::*;
   import isa_pkg::*;

   localparam int    N_INSTR        = 150;
   localparam int    N_DATA         = 64;
   // the last eight instructions store x0..x7 and no branch skips them
   localparam int    LAST_RAND      = N_INSTR - 9;
   localparam word_t DATA_BASE      = 32'h0000_0400;
   localparam int    TIMEOUT_CYCLES = N_INSTR * 120;

   typedef enum int {K_ADD, K_SUB, K_SLT, K_SLLI, K_BEQ, K_BNE, K_LW, K_SW} kind_t;

   logic  i_clk;
   logic  i_rst;
   logic  o_ibus_cyc;
   word_t o_ibus_adr;
   word_t i_ibus_rdt;
   logic  i_ibus_ack;
   logic  o_dbus_cyc;
   logic  o_dbus_we;
   word_t o_dbus_adr;
   word_t o_dbus_dat;
   word_t i_dbus_rdt;
   logic  i_dbus_ack;

   // the model reads the program fields and the DUT reads the encoded words
   kind_t    p_kind [N_INSTR];
   reg_idx_t p_rd [N_INSTR];
   reg_idx_t p_rs1 [N_INSTR];
   reg_idx_t p_rs2 [N_INSTR];
   word_t    p_imm [N_INSTR];
   word_t    imem [N_INSTR];
   word_t    dmem_bus [N_DATA];
   word_t    dmem_model [N_DATA];
   word_t    m_regs [8];
   word_t    m_pc;

   logic  exp_valid;
   logic  exp_we;
   word_t exp_adr;
   word_t exp_dat;
   logic  ib_busy;
   word_t ib_adr;
   int    ib_delay;
   logic  db_busy;
   logic  db_we;
   word_t db_adr;
   word_t db_dat;
   int    db_delay;
   int    seed;
   int    cycle;
   int    n_fetch;
   int    n_data;
   int    err_fetch;
   int    err_data;
   int    err_bus;
   logic  done;
   logic  timed_out;

   bit_core_top i_bit_core_top (
      .i_clk      (i_clk),
      .i_rst      (i_rst),
      .o_ibus_cyc (o_ibus_cyc),
      .o_ibus_adr (o_ibus_adr),
      .i_ibus_rdt (i_ibus_rdt),
      .i_ibus_ack (i_ibus_ack),
      .o_dbus_cyc (o_dbus_cyc),
      .o_dbus_we  (o_dbus_we),
      .o_dbus_adr (o_dbus_adr),
      .o_dbus_dat (o_dbus_dat),
      .i_dbus_rdt (i_dbus_rdt),
      .i_dbus_ack (i_dbus_ack)
   );

   initial begin
      i_clk = 1'b0;
      forever #4 i_clk = ~i_clk;
   end

   function automatic int rand_below(input int n);
      return int'($unsigned($random(seed)) % n);
   endfunction

   // every bit of the word address takes part in the pattern
   function automatic word_t fill_word(input int idx);
      word_t a;
      a = DATA_BASE + word_t'(idx * 4);
      return (a * 32'h9E37_79B1) ^ {a[15:0], ~a[31:16]};
   endfunction

   function automatic int data_index(input word_t adr);
      return int'((adr - DATA_BASE) >> 2);
   endfunction

   function automatic logic in_data_area(input word_t adr);
      return (adr >= DATA_BASE) && (adr < DATA_BASE + word_t'(N_DATA * 4));
   endfunction

   function automatic word_t encode_instr(input int i);
      logic [4:0] rd5;
      logic [4:0] rs15;
      logic [4:0] rs25;
      word_t      imm;
      rd5  = {2'b00, p_rd[i]};
      rs15 = {2'b00, p_rs1[i]};
      rs25 = {2'b00, p_rs2[i]};
      imm  = p_imm[i];
      case (p_kind[i])
         K_ADD:  return {7'b0000000, rs25, rs15, F3_ADD_SUB, rd5, OPC_OP};
         K_SUB:  return {7'b0100000, rs25, rs15, F3_ADD_SUB, rd5, OPC_OP};
         K_SLT:  return {7'b0000000, rs25, rs15, F3_SLT, rd5, OPC_OP};
         K_SLLI: return {7'b0000000, imm[4:0], rs15, F3_SLL, rd5, OPC_OPIMM};
         K_BEQ:  return {imm[12], imm[10:5], rs25, rs15, F3_BEQ, imm[4:1], imm[11], OPC_BRANCH};
         K_BNE:  return {imm[12], imm[10:5], rs25, rs15, F3_BNE, imm[4:1], imm[11], OPC_BRANCH};
         K_LW:   return {imm[11:0], rs15, F3_LW_SW, rd5, OPC_LOAD};
         default: return {imm[11:5], rs25, rs15, F3_LW_SW, imm[4:0], OPC_STORE};
      endcase
   endfunction

   task automatic make_program();
      int i;
      int k;
      for (i = 0; i < N_INSTR; i++) begin
         p_rs1[i]  = reg_idx_t'(rand_below(8));
         p_rs2[i]  = reg_idx_t'(rand_below(8));
         p_rd[i]   = reg_idx_t'(rand_below(8));
         p_imm[i]  = DATA_BASE + word_t'(4 * rand_below(N_DATA));
         p_kind[i] = kind_t'(rand_below(8));
         if (i < 7) begin
            // the first loads give x1..x7 known values
            p_kind[i] = K_LW;
            p_rd[i]   = reg_idx_t'(i + 1);
            p_imm[i]  = DATA_BASE + word_t'(4 * i);
         end else if (i > LAST_RAND) begin
            p_kind[i] = K_SW;
            p_rs2[i]  = reg_idx_t'(i - LAST_RAND - 1);
            p_imm[i]  = DATA_BASE + word_t'(4 * (N_DATA - 8 + i - LAST_RAND - 1));
         end else if (p_kind[i] == K_SLLI) begin
            p_imm[i] = word_t'(rand_below(32));
         end else if (p_kind[i] == K_BEQ || p_kind[i] == K_BNE) begin
            if (i == LAST_RAND) begin
               p_kind[i] = K_ADD;
            end else begin
               if (rand_below(4) == 0)
                  p_rs2[i] = p_rs1[i];
               k = 1 + rand_below(6);
               if (i + k > LAST_RAND)
                  k = LAST_RAND - i;
               p_imm[i] = word_t'(4 * k);
            end
         end
         // memory ops address from x0 so they stay inside the data area
         if (p_kind[i] == K_LW || p_kind[i] == K_SW)
            p_rs1[i] = '0;
         imem[i] = encode_instr(i);
      end
   endtask

   task automatic model_step();
      int    i;
      word_t a;
      word_t b;
      word_t res;
      word_t adr;
      word_t next;
      i    = int'(m_pc >> 2);
      a    = m_regs[p_rs1[i]];
      b    = m_regs[p_rs2[i]];
      adr  = a + p_imm[i];
      next = m_pc + 32'd4;
      res  = '0;
      case (p_kind[i])
         K_ADD:  res = a + b;
         K_SUB:  res = a - b;
         K_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
         K_SLLI: res = a << p_imm[i][4:0];
         K_BEQ:  if (a == b) next = m_pc + p_imm[i];
         K_BNE:  if (a != b) next = m_pc + p_imm[i];
         K_LW:   res = dmem_model[data_index(adr)];
         default: dmem_model[data_index(adr)] = b;
      endcase
      if (p_kind[i] inside {K_LW, K_SW}) begin
         exp_valid = 1'b1;
         exp_we    = (p_kind[i] == K_SW);
         exp_adr   = adr;
         exp_dat   = b;
      end
      if (p_kind[i] inside {K_ADD, K_SUB, K_SLT, K_SLLI, K_LW} && p_rd[i] != '0)
         m_regs[p_rd[i]] = res;
      m_pc = next;
   endtask

   task automatic fetch_start();
      n_fetch++;
      if (exp_valid) begin
         $display("the instruction before the fetch at %0t ns made no data access", $time);
         err_data++;
         exp_valid = 1'b0;
      end
      if (o_ibus_adr != m_pc) begin
         $display("error at %0t ns: o_ibus_adr is %h, expected %h", $time, o_ibus_adr, m_pc);
         err_fetch++;
         done = 1'b1;
      end else if (m_pc >= word_t'(N_INSTR * 4)) begin
         done = 1'b1;
      end else begin
         model_step();
      end
   endtask

   task automatic data_start();
      n_data++;
      if (!exp_valid) begin
         $display("unexpected data bus cycle at %0t ns", $time);
         err_data++;
      end else begin
         if (o_dbus_adr != exp_adr) begin
            $display("error at %0t ns: o_dbus_adr is %h, expected %h", $time, o_dbus_adr, exp_adr);
            err_data++;
         end
         if (o_dbus_we != exp_we) begin
            $display("error at %0t ns: o_dbus_we is %b, expected %b", $time, o_dbus_we, exp_we);
            err_data++;
         end
         if (exp_we && o_dbus_dat != exp_dat) begin
            $display("error at %0t ns: o_dbus_dat is %h, expected %h", $time, o_dbus_dat, exp_dat);
            err_data++;
         end
      end
      if (!in_data_area(o_dbus_adr)) begin
         $display("data access at %0t ns falls outside the data area", $time);
         err_data++;
      end
      exp_valid = 1'b0;
   endtask

   // runs once per falling edge and both buses answer after a random delay
   task automatic serve_buses();
      i_ibus_ack = 1'b0;
      i_dbus_ack = 1'b0;
      if ((ib_busy && !o_ibus_cyc) || (db_busy && !o_dbus_cyc)) begin
         $display("a bus request was dropped before its ack at %0t ns", $time);
         err_bus++;
         ib_busy = ib_busy & o_ibus_cyc;
         db_busy = db_busy & o_dbus_cyc;
      end
      if (o_ibus_cyc) begin
         if (!ib_busy) begin
            ib_busy  = 1'b1;
            ib_adr   = o_ibus_adr;
            ib_delay = rand_below(6);
            fetch_start();
         end else if (o_ibus_adr != ib_adr) begin
            $display("error at %0t ns: o_ibus_adr is %h, expected %h", $time, o_ibus_adr, ib_adr);
            err_bus++;
         end
         if (ib_delay > 0) begin
            ib_delay--;
         end else if (!done) begin
            i_ibus_ack = 1'b1;
            i_ibus_rdt = imem[int'(ib_adr >> 2)];
            ib_busy    = 1'b0;
         end
      end
      if (o_dbus_cyc) begin
         if (!db_busy) begin
            db_busy  = 1'b1;
            db_adr   = o_dbus_adr;
            db_we    = o_dbus_we;
            db_dat   = o_dbus_dat;
            db_delay = rand_below(6);
            data_start();
         end else if (o_dbus_adr != db_adr || o_dbus_we != db_we || o_dbus_dat != db_dat) begin
            $display("the data bus request changed before its ack at %0t ns", $time);
            err_bus++;
         end
         if (db_delay > 0) begin
            db_delay--;
         end else begin
            i_dbus_ack = 1'b1;
            db_busy    = 1'b0;
            if (in_data_area(db_adr) && db_we)
               dmem_bus[data_index(db_adr)] = db_dat;
            else if (in_data_area(db_adr))
               i_dbus_rdt = dmem_bus[data_index(db_adr)];
         end
      end
   endtask

   initial begin
      seed       = 52;
      i_rst      = 1'b1;
      i_ibus_rdt = '0;
      i_ibus_ack = 1'b0;
      i_dbus_rdt = '0;
      i_dbus_ack = 1'b0;
      m_pc       = '0;
      exp_valid  = 1'b0;
      exp_we     = 1'b0;
      exp_adr    = '0;
      exp_dat    = '0;
      ib_busy    = 1'b0;
      db_busy    = 1'b0;
      cycle      = 0;
      n_fetch    = 0;
      n_data     = 0;
      err_fetch  = 0;
      err_data   = 0;
      err_bus    = 0;
      done       = 1'b0;
      timed_out  = 1'b0;
      for (int r = 0; r < 8; r++)
         m_regs[r] = '0;
      for (int d = 0; d < N_DATA; d++) begin
         dmem_bus[d]   = fill_word(d);
         dmem_model[d] = fill_word(d);
      end
      make_program();

      repeat (16) @(posedge i_clk);
      @(negedge i_clk);
      i_rst = 1'b0;
      @(negedge i_clk);
      if (!o_ibus_cyc) begin
         $display("no fetch request after reset");
         err_bus++;
      end

      while (!done && !timed_out) begin
         cycle++;
         if (cycle > TIMEOUT_CYCLES) begin
            $display("timeout: the program did not finish within %0d cycles", TIMEOUT_CYCLES);
            timed_out = 1'b1;
         end else begin
            serve_buses();
            @(negedge i_clk);
         end
      end

      $display("fetches %0d, data accesses %0d, fetch errors %0d, data errors %0d, bus errors %0d",
               n_fetch, n_data, err_fetch, err_data, err_bus);
      if (err_fetch + err_data + err_bus == 0 && !timed_out) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

// File: source/bit_core_top.sv
module bit_core_top (
   input  logic            i_clk,
   input  logic            i_rst,
   output logic            o_ibus_cyc,
   output core_pkg::word_t o_ibus_adr,
   input  core_pkg::word_t i_ibus_rdt,
   input  logic            i_ibus_ack,
   output logic            o_dbus_cyc,
   output logic            o_dbus_we,
   output core_pkg::word_t o_dbus_adr,
   output core_pkg::word_t o_dbus_dat,
   input  core_pkg::word_t i_dbus_rdt,
   input  logic            i_dbus_ack
);

   logic rf_rreq;
   logic rf_ready;
   logic alu_cmp;
   logic sh_done;
   logic rd_bit;
   logic rs1_bit;
   logic rs2_bit;

   serial_ctrl_if u_ctrl ();
   op_if          u_op ();

   serial_state u_state (
      .i_clk      (i_clk),
      .i_rst      (i_rst),
      .i_ibus_ack (i_ibus_ack),
      .i_dbus_ack (i_dbus_ack),
      .i_rf_ready (rf_ready),
      .i_alu_cmp  (alu_cmp),
      .i_sh_done  (sh_done),
      .o_rf_rreq  (rf_rreq),
      .o_dbus_cyc (o_dbus_cyc),
      .o_ibus_cyc (o_ibus_cyc),
      .ctrl       (u_ctrl),
      .op         (u_op)
   );

   instr_decode u_decode (
      .i_clk      (i_clk),
      .i_rst      (i_rst),
      .i_ibus_ack (i_ibus_ack),
      .i_ibus_rdt (i_ibus_rdt),
      .ctrl       (u_ctrl),
      .op         (u_op)
   );

   serial_regfile u_regfile (
      .i_clk      (i_clk),
      .i_rst      (i_rst),
      .i_rf_rreq  (rf_rreq),
      .o_rf_ready (rf_ready),
      .i_rd_bit   (rd_bit),
      .o_rs1_bit  (rs1_bit),
      .o_rs2_bit  (rs2_bit),
      .ctrl       (u_ctrl),
      .op         (u_op)
   );

   serial_alu u_alu (
      .i_clk      (i_clk),
      .i_rst      (i_rst),
      .i_rs1_bit  (rs1_bit),
      .i_rs2_bit  (rs2_bit),
      .i_dbus_rdt (i_dbus_rdt),
      .i_dbus_ack (i_dbus_ack),
      .o_rd_bit   (rd_bit),
      .o_alu_cmp  (alu_cmp),
      .o_sh_done  (sh_done),
      .o_dbus_adr (o_dbus_adr),
      .o_dbus_dat (o_dbus_dat),
      .o_dbus_we  (o_dbus_we),
      .ctrl       (u_ctrl),
      .op         (u_op)
   );

   serial_pc u_pc (
      .i_clk      (i_clk),
      .i_rst      (i_rst),
      .o_ibus_adr (o_ibus_adr),
      .ctrl       (u_ctrl),
      .op         (u_op)
   );

endmodule

// File: source/serial_pc.sv
module serial_pc (
   input  logic            i_clk,
   input  logic            i_rst,
   output core_pkg::word_t o_ibus_adr,
   serial_ctrl_if.datapath ctrl,
   op_if.user              op
);
   import core_pkg::*;

   word_t pc;
   logic  carry_r;
   logic  addend;
   logic  cin;
   logic  sum;

   // pc+4 adds a single one at bit 2, a taken branch adds the immediate
   assign addend = ctrl.ctrl_jump ? op.imm_bit : (ctrl.cnt_idx == cnt_t'(2));
   assign cin    = (ctrl.cnt_idx == '0) ? 1'b0 : carry_r;
   assign sum    = pc[0] ^ addend ^ cin;

   // the pc rotates through bit 0 and is back in place after 32 bits
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         pc      <= '0;
         carry_r <= 1'b0;
      end else if (ctrl.pc_en) begin
         pc      <= {sum, pc[31:1]};
         carry_r <= (pc[0] & addend) | (pc[0] & cin) | (addend & cin);
      end
   end

   assign o_ibus_adr = {pc[31:2], 2'b00};

endmodule

// File: source/serial_alu.sv
module serial_alu (
   input  logic            i_clk,
   input  logic            i_rst,
   input  logic            i_rs1_bit,
   input  logic            i_rs2_bit,
   input  core_pkg::word_t i_dbus_rdt,
   input  logic            i_dbus_ack,
   output logic            o_rd_bit,
   output logic            o_alu_cmp,
   output logic            o_sh_done,
   output core_pkg::word_t o_dbus_adr,
   output core_pkg::word_t o_dbus_dat,
   output logic            o_dbus_we,
   serial_ctrl_if.datapath ctrl,
   op_if.user              op
);
   import core_pkg::*;

   word_t bufreg;
   word_t st_dat;
   cnt_t  sh_cnt;
   logic  carry_r;
   logic  eq_r;
   logic  cmp_r;
   logic  first;
   logic  do_sub;
   logic  op_b;
   logic  cin;
   logic  sum;
   logic  eq;
   logic  lt;
   logic  buf_in;

   // compares subtract rs2, memory ops add the immediate to rs1
   assign first  = (ctrl.cnt_idx == '0);
   assign do_sub = op.sub_op | op.slt_op | op.branch_op;
   assign op_b   = (op.mem_op ? op.imm_bit : i_rs2_bit) ^ do_sub;
   assign cin    = first ? do_sub : carry_r;
   assign sum    = i_rs1_bit ^ op_b ^ cin;

   // both results are only meaningful at bit 31
   assign eq = (first | eq_r) & (i_rs1_bit == i_rs2_bit);
   assign lt = (i_rs1_bit ^ i_rs2_bit) ? i_rs1_bit : sum;
   assign o_alu_cmp = op.branch_op ? eq : lt;
   assign o_sh_done = (sh_cnt == op.shamt);

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         carry_r <= 1'b0;
         eq_r    <= 1'b0;
         cmp_r   <= 1'b0;
         sh_cnt  <= '0;
      end else if (ctrl.cnt_en) begin
         carry_r <= (i_rs1_bit & op_b) | (i_rs1_bit & cin) | (op_b & cin);
         eq_r    <= eq;
         sh_cnt  <= '0;
         if (ctrl.cnt_done)
            cmp_r <= o_alu_cmp;
      end else if (ctrl.sh_en & !o_sh_done) begin
         sh_cnt <= sh_cnt + cnt_t'(1);
      end
   end

   // init fills the buffer with rs1 or the address, the second pass drains it
   assign buf_in = ctrl.init & (op.mem_op ? sum : i_rs1_bit);

   always_ff @(posedge i_clk) begin
      if (i_dbus_ack & op.mem_op & !op.store)
         bufreg <= i_dbus_rdt;
      else if (!ctrl.bufreg_hold) begin
         if (ctrl.cnt_en)
            bufreg <= {buf_in, bufreg[31:1]};
         else
            bufreg <= {bufreg[30:0], 1'b0};
      end
      if (ctrl.cnt_en & ctrl.init)
         st_dat <= {i_rs2_bit, st_dat[31:1]};
   end

   always_comb begin
      if (op.slt_op)
         o_rd_bit = first & cmp_r;
      else if (op.shift_op | op.mem_op)
         o_rd_bit = bufreg[0];
      else
         o_rd_bit = sum;
   end

   assign o_dbus_adr = {bufreg[31:2], 2'b00};
   assign o_dbus_dat = st_dat;
   assign o_dbus_we  = op.store;

endmodule

// File: source/serial_regfile.sv
module serial_regfile (
   input  logic            i_clk,
   input  logic            i_rst,
   input  logic            i_rf_rreq,
   output logic            o_rf_ready,
   input  logic            i_rd_bit,
   output logic            o_rs1_bit,
   output logic            o_rs2_bit,
   serial_ctrl_if.datapath ctrl,
   op_if.user              op
);
   import core_pkg::*;
   import isa_pkg::*;

   word_t regs [2**$bits(reg_idx_t)];
   logic  wr_en;

   // the register file is ready for a pass one cycle after the request
   always_ff @(posedge i_clk) begin
      if (i_rst)
         o_rf_ready <= 1'b0;
      else
         o_rf_ready <= i_rf_rreq;
   end

   assign wr_en = ctrl.rd_en & op.rd_op & (op.rd != '0);

   // x0 is cleared by reset and is never a write target afterwards
   always_ff @(posedge i_clk) begin
      if (i_rst)
         regs[0] <= '0;
      else if (wr_en)
         regs[op.rd][ctrl.cnt_idx] <= i_rd_bit;
   end

   assign o_rs1_bit = regs[op.rs1][ctrl.cnt_idx];
   assign o_rs2_bit = regs[op.rs2][ctrl.cnt_idx];

   a_x0_zero : assert property (
      @(posedge i_clk) disable iff (i_rst)
      !((op.rs1 == '0 && o_rs1_bit) || (op.rs2 == '0 && o_rs2_bit)));

endmodule

// File: source/instr_decode.sv
module instr_decode (
   input  logic            i_clk,
   input  logic            i_rst,
   input  logic            i_ibus_ack,
   input  core_pkg::word_t i_ibus_rdt,
   serial_ctrl_if.datapath ctrl,
   op_if.decode            op
);
   import core_pkg::*;
   import isa_pkg::*;

   word_t      ir;
   logic [6:0] opcode;
   logic [2:0] funct3;
   logic       is_op;
   logic       is_load;
   logic       is_store;
   word_t      imm_i;
   word_t      imm_s;
   word_t      imm_b;
   word_t      imm;

   // the instruction stays in place until the next fetch is acknowledged
   always_ff @(posedge i_clk) begin
      if (i_rst)
         ir <= '0;
      else if (i_ibus_ack)
         ir <= i_ibus_rdt;
   end

   assign opcode   = ir[6:0];
   assign funct3   = ir[14:12];
   assign is_op    = (opcode == OPC_OP);
   assign is_load  = (opcode == OPC_LOAD) & (funct3 == F3_LW_SW);
   assign is_store = (opcode == OPC_STORE) & (funct3 == F3_LW_SW);

   assign op.branch_op = (opcode == OPC_BRANCH) & ((funct3 == F3_BEQ) | (funct3 == F3_BNE));
   assign op.cond_bne  = (funct3 == F3_BNE);
   assign op.mem_op    = is_load | is_store;
   assign op.store     = is_store;
   assign op.shift_op  = (opcode == OPC_OPIMM) & (funct3 == F3_SLL);
   assign op.slt_op    = is_op & (funct3 == F3_SLT);
   assign op.sub_op    = is_op & (funct3 == F3_ADD_SUB) & ir[30];
   assign op.rd_op     = (is_op & ((funct3 == F3_ADD_SUB) | (funct3 == F3_SLT)))
                       | op.shift_op | is_load;

   // only the low three bits of each register field are decoded
   assign op.rs1   = ir[17:15];
   assign op.rs2   = ir[22:20];
   assign op.rd    = ir[9:7];
   assign op.shamt = ir[24:20];

   assign imm_i = {{20{ir[31]}}, ir[31:20]};
   assign imm_s = {{20{ir[31]}}, ir[31:25], ir[11:7]};
   assign imm_b = {{20{ir[31]}}, ir[7], ir[30:25], ir[11:8], 1'b0};

   assign imm = is_store     ? imm_s :
                op.branch_op ? imm_b : imm_i;

   assign op.imm_bit = imm[ctrl.cnt_idx];

endmodule

// File: source/serial_state.sv
module serial_state (
   input  logic         i_clk,
   input  logic         i_rst,
   input  logic         i_ibus_ack,
   input  logic         i_dbus_ack,
   input  logic         i_rf_ready,
   input  logic         i_alu_cmp,
   input  logic         i_sh_done,
   output logic         o_rf_rreq,
   output logic         o_dbus_cyc,
   output logic         o_ibus_cyc,
   serial_ctrl_if.state ctrl,
   op_if.user           op
);
   import core_pkg::*;

   logic [3:0] cnt_r;
   logic [2:0] cnt_hi;
   cnt_t       cnt_idx;
   logic       cnt_en;
   logic       init;
   logic       cnt_done;
   logic       ctrl_jump;
   logic       stage_two_req;
   logic       stage_two_pending;
   logic       wait_shift;
   logic       two_stage_op;
   logic       take_branch;

   // one-hot phase gives the two low index bits, the count gives the rest
   assign cnt_idx = {cnt_hi, cnt_r[3] | cnt_r[2], cnt_r[3] | cnt_r[1]};

   assign two_stage_op = op.slt_op | op.mem_op | op.branch_op | op.shift_op;

   // the ALU holds the equality result of rs1 and rs2 at the last bit of init
   assign take_branch = op.branch_op & (i_alu_cmp ^ op.cond_bne);

   // a fetch, a finished compare, a finished shift or a data ack each
   // opens the next register file pass
   assign o_rf_rreq = i_ibus_ack
                    | (stage_two_req & (op.slt_op | op.branch_op))
                    | (wait_shift & i_sh_done)
                    | (o_dbus_cyc & i_dbus_ack);

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         cnt_r             <= 4'b0001;
         cnt_hi            <= 3'd0;
         cnt_en            <= 1'b0;
         init              <= 1'b0;
         cnt_done          <= 1'b0;
         ctrl_jump         <= 1'b0;
         stage_two_req     <= 1'b0;
         stage_two_pending <= 1'b0;
         wait_shift        <= 1'b0;
         o_dbus_cyc        <= 1'b0;
         o_ibus_cyc        <= 1'b1;
      end else begin
         if (cnt_en) begin
            cnt_r             <= {cnt_r[2:0], cnt_r[3]};
            cnt_hi            <= cnt_hi + {2'd0, cnt_r[3]};
            stage_two_pending <= init;
         end
         cnt_done      <= cnt_en & (cnt_idx == cnt_t'(CNT_LAST - 1'b1));
         stage_two_req <= cnt_done & init;

         if (i_rf_ready)
            cnt_en <= 1'b1;
         if (cnt_done)
            cnt_en <= 1'b0;

         if (i_rf_ready & !stage_two_pending)
            init <= two_stage_op;
         if (cnt_done) begin
            init      <= 1'b0;
            ctrl_jump <= init & take_branch;
         end

         if (stage_two_req & op.shift_op)
            wait_shift <= 1'b1;
         if (wait_shift & i_sh_done)
            wait_shift <= 1'b0;

         if (stage_two_req & op.mem_op)
            o_dbus_cyc <= 1'b1;
         if (i_dbus_ack)
            o_dbus_cyc <= 1'b0;

         // next fetch starts once the last pass of the instruction is over
         if (i_ibus_ack)
            o_ibus_cyc <= 1'b0;
         if (cnt_done & !init)
            o_ibus_cyc <= 1'b1;
      end
   end

   assign ctrl.cnt_en    = cnt_en;
   assign ctrl.init      = init;
   assign ctrl.cnt_idx   = cnt_idx;
   assign ctrl.cnt_done  = cnt_done;
   assign ctrl.ctrl_jump = ctrl_jump;
   assign ctrl.pc_en     = cnt_en & !init;
   assign ctrl.rd_en     = cnt_en & !init;
   assign ctrl.sh_en     = wait_shift;
   // the buffer register only moves during a pass or while shift steps remain
   assign ctrl.bufreg_hold = !cnt_en & !(wait_shift & !i_sh_done);

   a_dbus_outside_pass : assert property (
      @(posedge i_clk) disable iff (i_rst) !(o_dbus_cyc && cnt_en));

   a_pass_length : assert property (
      @(posedge i_clk) disable iff (i_rst) $rose(cnt_en) |-> ##31 cnt_done);

endmodule

// File: source/op_if.sv
interface op_if;
   import core_pkg::*;
   import isa_pkg::*;

   logic     branch_op;
   logic     cond_bne;
   logic     mem_op;
   logic     store;
   logic     shift_op;
   logic     slt_op;
   logic     sub_op;
   logic     rd_op;
   // immediate bit at the current serial index
   logic     imm_bit;
   reg_idx_t rs1;
   reg_idx_t rs2;
   reg_idx_t rd;
   cnt_t     shamt;

   modport decode (
      output branch_op, cond_bne, mem_op, store, shift_op, slt_op, sub_op, rd_op,
      output imm_bit, rs1, rs2, rd, shamt
   );

   modport user (
      input branch_op, cond_bne, mem_op, store, shift_op, slt_op, sub_op, rd_op,
      input imm_bit, rs1, rs2, rd, shamt
   );

endinterface

// File: source/serial_ctrl_if.sv
interface serial_ctrl_if;
   import core_pkg::*;

   // a serial bit moves through the datapath this cycle
   logic cnt_en;
   // first pass of a two-stage instruction
   logic init;
   cnt_t cnt_idx;
   logic cnt_done;
   // pc takes the immediate target instead of pc+4
   logic ctrl_jump;
   logic pc_en;
   logic rd_en;
   logic bufreg_hold;
   // shift steps may run between the two passes
   logic sh_en;

   modport state (
      output cnt_en, init, cnt_idx, cnt_done, ctrl_jump,
      output pc_en, rd_en, bufreg_hold, sh_en
   );

   modport datapath (
      input cnt_en, init, cnt_idx, cnt_done, ctrl_jump,
      input pc_en, rd_en, bufreg_hold, sh_en
   );

endinterface

// File: source/isa_pkg.sv
package isa_pkg;

   // register numbers are 3 bits wide for eight registers with x0 fixed at zero
   localparam int REG_W = 3;

   typedef logic [REG_W-1:0] reg_idx_t;

   // major opcodes of the supported subset
   localparam logic [6:0] OPC_OP     = 7'b0110011;
   localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
   localparam logic [6:0] OPC_BRANCH = 7'b1100011;
   localparam logic [6:0] OPC_LOAD   = 7'b0000011;
   localparam logic [6:0] OPC_STORE  = 7'b0100011;

   // add and sub share one funct3 value and are told apart by bit 30
   localparam logic [2:0] F3_ADD_SUB = 3'b000;
   localparam logic [2:0] F3_SLT     = 3'b010;
   localparam logic [2:0] F3_SLL     = 3'b001;
   localparam logic [2:0] F3_BEQ     = 3'b000;
   localparam logic [2:0] F3_BNE     = 3'b001;
   localparam logic [2:0] F3_LW_SW   = 3'b010;

endpackage

// File: source/core_pkg.sv
package core_pkg;

   // width of a data or address word
   localparam int WORD_W = 32;

   // width of the serial bit index
   localparam int CNT_W = $clog2(WORD_W);

   // one data or address word
   typedef logic [WORD_W-1:0] word_t;

   // index of the bit that moves through the datapath this cycle
   typedef logic [CNT_W-1:0] cnt_t;

   // index of the final bit of a 32-cycle pass
   localparam cnt_t CNT_LAST = cnt_t'(WORD_W - 1);

endpackage
